//--- dcache_cfg.svh
`ifndef DCACHE_CFG_SVH
`define DCACHE_CFG_SVH

// bus word width in bits
`define DCACHE_DATA_WIDTH 32

// simulation geometry of 4 ways, 4 sets and 4 words per line
`define DCACHE_WAY_BITS 2
`define DCACHE_SET_BITS 2
`define DCACHE_WORD_BITS 2

// main memory size, log2 of words
`define DCACHE_MEM_ADDR_BITS 10

`endif

//--- dcache_pkg.sv
`include "dcache_cfg.svh"

package dcache_pkg;

    localparam int DATA_BYTES = `DCACHE_DATA_WIDTH / 8;
    localparam int ALIGN_BITS = $clog2(DATA_BYTES);
    localparam int TAG_BITS   = `DCACHE_DATA_WIDTH - `DCACHE_SET_BITS
                                - `DCACHE_WORD_BITS - ALIGN_BITS;

    typedef logic [`DCACHE_DATA_WIDTH - 1:0] word_t;
    typedef logic [DATA_BYTES - 1:0]         wrten_t;
    typedef logic [TAG_BITS - 1:0]           tag_t;
    typedef logic [`DCACHE_SET_BITS - 1:0]   index_t;
    typedef logic [`DCACHE_WORD_BITS - 1:0]  offset_t;
    typedef logic [`DCACHE_WAY_BITS - 1:0]   way_t;

    // physical byte address split
    typedef struct packed {
        tag_t                    tag;
        index_t                  index;
        offset_t                 offset;
        logic [ALIGN_BITS - 1:0] zeros;
    } paddr_t;

    // word position inside the line RAM
    typedef struct packed {
        way_t    way;
        index_t  index;
        offset_t offset;
    } cpos_t;

    typedef struct packed {
        logic valid;
        logic dirty;
        tag_t tag;
    } line_meta_t;

    typedef struct packed {
        logic   valid;
        logic   is_write;
        paddr_t addr;
        wrten_t write_en;
        word_t  data;
    } dbus_req_t;

    typedef struct packed {
        logic  addr_ok;
        logic  data_ok;
        word_t data;
    } dbus_resp_t;

    typedef struct packed {
        logic   valid;
        logic   is_write;
        paddr_t addr;
        word_t  wdata;
    } cbus_req_t;

    typedef struct packed {
        logic  okay;
        logic  last;
        word_t rdata;
    } cbus_resp_t;

    typedef enum logic [1:0] {
        IDLE,
        READ,
        WRITE
    } miss_state_t;

endpackage

//--- plru.sv
`timescale 1ns/1ps
`include "dcache_cfg.svh"

module plru #(
    parameter int WAY_BITS = `DCACHE_WAY_BITS
) (
    input  logic [(1 << WAY_BITS) - 2:0] select,
    input  logic [WAY_BITS - 1:0]        touched_way,
    output logic [WAY_BITS - 1:0]        victim_way,
    output logic [(1 << WAY_BITS) - 2:0] new_select
);

    // heap-ordered tree, node n has children 2n+1 and 2n+2
    // a set bit means the older half is the right subtree
    always_comb begin
        int node;
        node = 0;
        victim_way = '0;
        for (int lvl = 0; lvl < WAY_BITS; lvl++) begin
            victim_way[WAY_BITS - 1 - lvl] = select[node];
            node = 2 * node + 1 + int'(select[node]);
        end
    end

    // point every node on the touched path away from it
    always_comb begin
        int node;
        logic dir;
        node = 0;
        new_select = select;
        for (int lvl = 0; lvl < WAY_BITS; lvl++) begin
            dir = touched_way[WAY_BITS - 1 - lvl];
            new_select[node] = ~dir;
            node = 2 * node + 1 + int'(dir);
        end
    end

endmodule

//--- dual_port_bram.sv
`timescale 1ns/1ps

module dual_port_bram (
    input  logic               clk,
    input  logic               resetn,
    input  dcache_pkg::wrten_t write_en_a,
    input  dcache_pkg::cpos_t  addr_a,
    input  dcache_pkg::word_t  wdata_a,
    output dcache_pkg::word_t  rdata_a,
    input  dcache_pkg::wrten_t write_en_b,
    input  dcache_pkg::cpos_t  addr_b,
    input  dcache_pkg::word_t  wdata_b,
    output dcache_pkg::word_t  rdata_b
);
    import dcache_pkg::*;

    localparam int DEPTH = 1 << $bits(cpos_t);

    word_t mem [DEPTH];

    // byte-lane writes from both ports
    always_ff @(posedge clk) begin
        for (int i = 0; i < DATA_BYTES; i++) begin
            if (write_en_a[i])
                mem[addr_a][8 * i +: 8] <= wdata_a[8 * i +: 8];
            if (write_en_b[i])
                mem[addr_b][8 * i +: 8] <= wdata_b[8 * i +: 8];
        end
    end

    // read first, a writing port sees the old word next cycle
    always_ff @(posedge clk) begin
        if (resetn) begin
            rdata_a <= '0;
            rdata_b <= '0;
        end else begin
            rdata_a <= mem[addr_a];
            rdata_b <= mem[addr_b];
        end
    end

    no_write_collision: assert property (@(posedge clk) disable iff (resetn)
        !((|write_en_a) && (|write_en_b) && addr_a == addr_b))
        else $error("both ports write position %0h", addr_a);

endmodule

//--- dcache.sv
`timescale 1ns/1ps
`include "dcache_cfg.svh"

module dcache (
    input  logic                   clk,
    input  logic                   resetn,
    input  dcache_pkg::dbus_req_t  dbus_req,
    output dcache_pkg::dbus_resp_t dbus_resp,
    output dcache_pkg::cbus_req_t  cbus_req,
    input  dcache_pkg::cbus_resp_t cbus_resp
);
    import dcache_pkg::*;

    localparam int NUM_WAYS  = 1 << `DCACHE_WAY_BITS;
    localparam int NUM_SETS  = 1 << `DCACHE_SET_BITS;
    localparam int NUM_WORDS = 1 << `DCACHE_WORD_BITS;

    typedef logic [NUM_WAYS - 2:0] select_t;

    // per-set metadata
    line_meta_t set_lines [NUM_SETS][NUM_WAYS];
    select_t    set_select [NUM_SETS];

    paddr_t req_addr;
    assign req_addr = dbus_req.addr;

    // parallel tag compare and one-hot encode
    logic [NUM_WAYS - 1:0] hit_bits;
    logic                  req_hit;
    way_t                  req_way;

    always_comb begin
        req_way = '0;
        for (int i = 0; i < NUM_WAYS; i++) begin
            hit_bits[i] = set_lines[req_addr.index][i].valid &&
                set_lines[req_addr.index][i].tag == req_addr.tag;
            if (hit_bits[i])
                req_way = req_way | way_t'(i);
        end
    end
    assign req_hit = |hit_bits;

    way_t    victim_way;
    select_t new_select;

    plru u_plru (
        .select      (set_select[req_addr.index]),
        .touched_way (req_way),
        .victim_way  (victim_way),
        .new_select  (new_select)
    );

    // miss stage
    miss_state_t            miss_state;
    paddr_t                 miss_addr;
    cpos_t                  miss_pos;
    logic [NUM_WORDS - 1:0] miss_ready;
    line_meta_t             miss_vline;
    // victim buffer fills one cycle behind the refill beat
    logic                   miss_vwrten;
    offset_t                miss_voffset;
    word_t                  miss_victim [NUM_WORDS];

    logic   miss_busy;
    logic   miss_avail;
    logic   miss_dirty;
    word_t  miss_rdata;
    wrten_t miss_write_en;

    assign miss_busy     = miss_state != IDLE;
    assign miss_dirty    = miss_vline.valid && miss_vline.dirty;
    assign miss_avail    = miss_state == IDLE || (miss_state == WRITE && cbus_resp.last);
    assign miss_write_en = (miss_state == READ && cbus_resp.okay) ? '1 : '0;

    // a hit on the refilling line waits for its word
    logic req_in_miss;
    logic req_ready;
    logic req_to_hit;
    logic req_to_miss;

    assign req_in_miss = miss_busy && req_way == miss_pos.way &&
        req_addr.index == miss_pos.index;
    assign req_ready   = req_hit && (!req_in_miss || miss_ready[req_addr.offset]);
    assign req_to_hit  = dbus_req.valid && req_ready;
    assign req_to_miss = dbus_req.valid && miss_avail && !req_hit;

    // hit stage on port a
    logic   hit_data_ok;
    word_t  hit_rdata;
    wrten_t hit_write_en;

    assign hit_write_en = (req_to_hit && dbus_req.is_write) ? dbus_req.write_en : '0;

    dual_port_bram u_bram (
        .clk        (clk),
        .resetn     (resetn),
        .write_en_a (hit_write_en),
        .addr_a     (cpos_t'{way: req_way, index: req_addr.index, offset: req_addr.offset}),
        .wdata_a    (dbus_req.data),
        .rdata_a    (hit_rdata),
        .write_en_b (miss_write_en),
        .addr_b     (miss_pos),
        .wdata_b    (cbus_resp.rdata),
        .rdata_b    (miss_rdata)
    );

    always_ff @(posedge clk) begin
        if (resetn) begin
            hit_data_ok <= 1'b0;
            miss_state  <= IDLE;
            miss_vwrten <= 1'b0;
            miss_ready  <= '0;
            for (int s = 0; s < NUM_SETS; s++) begin
                set_select[s] <= '0;
                for (int w = 0; w < NUM_WAYS; w++)
                    set_lines[s][w] <= '0;
            end
        end else begin
            hit_data_ok <= req_to_hit;
            miss_vwrten <= miss_state == READ && cbus_resp.okay;

            if (req_to_hit) begin
                set_select[req_addr.index] <= new_select;
                if (dbus_req.is_write)
                    set_lines[req_addr.index][req_way].dirty <= 1'b1;
            end

            case (miss_state)
                READ: begin
                    if (cbus_resp.okay)
                        miss_ready[miss_pos.offset] <= 1'b1;
                    if (cbus_resp.last)
                        miss_state <= miss_dirty ? WRITE : IDLE;
                end
                WRITE: begin
                    if (cbus_resp.last)
                        miss_state <= IDLE;
                end
                default: begin
                end
            endcase

            // install the new tag into the victim way right away
            if (req_to_miss) begin
                miss_state <= READ;
                miss_ready <= '0;
                set_lines[req_addr.index][victim_way] <=
                    line_meta_t'{valid: 1'b1, dirty: 1'b0, tag: req_addr.tag};
            end
        end
    end

    always_ff @(posedge clk) begin
        miss_voffset <= miss_pos.offset;
        if (miss_vwrten)
            miss_victim[miss_voffset] <= miss_rdata;
        if (miss_busy && cbus_resp.okay)
            miss_pos.offset <= offset_t'(miss_pos.offset + 1'b1);
        // writeback goes to the old line's address
        if (miss_state == READ && cbus_resp.last)
            miss_addr.tag <= miss_vline.tag;
        if (req_to_miss) begin
            miss_addr  <= req_addr;
            miss_pos   <= cpos_t'{way: victim_way, index: req_addr.index,
                                  offset: req_addr.offset};
            miss_vline <= set_lines[req_addr.index][victim_way];
        end
    end

    assign dbus_resp.addr_ok = req_ready;
    assign dbus_resp.data_ok = hit_data_ok;
    assign dbus_resp.data    = hit_rdata;

    assign cbus_req.valid    = miss_busy;
    assign cbus_req.is_write = miss_state == WRITE;
    assign cbus_req.addr     = miss_addr;
    assign cbus_req.wdata    = miss_victim[miss_pos.offset];

    data_ok_after_accept: assert property (@(posedge clk) disable iff (resetn)
        dbus_resp.data_ok |-> $past(dbus_req.valid && dbus_resp.addr_ok))
        else $error("data_ok without an accepted request");

    // memory only answers an active burst
    cbus_valid_tracks_state: assert property (@(posedge clk) disable iff (resetn)
        !cbus_resp.okay || cbus_req.valid)
        else $error("cache bus valid out of step with miss state");

endmodule

//--- cbus_memory.sv
`timescale 1ns/1ps
`include "dcache_cfg.svh"

module cbus_memory (
    input  logic                   clk,
    input  logic                   resetn,
    input  dcache_pkg::cbus_req_t  cbus_req,
    output dcache_pkg::cbus_resp_t cbus_resp
);
    import dcache_pkg::*;

    localparam int MEM_WORDS = 1 << `DCACHE_MEM_ADDR_BITS;

    word_t mem [MEM_WORDS];

    logic    busy;
    offset_t beat;
    logic    prev_valid;
    logic    burst_is_write;
    logic    start;
    paddr_t  beat_addr;
    logic [`DCACHE_MEM_ADDR_BITS - 1:0] word_idx;

    // new burst on valid rising or a change of direction
    assign start = cbus_req.valid && !busy &&
        (!prev_valid || cbus_req.is_write != burst_is_write);

    // wrap within the line
    always_comb begin
        beat_addr = cbus_req.addr;
        beat_addr.offset = offset_t'(cbus_req.addr.offset + beat);
    end
    assign word_idx = beat_addr[`DCACHE_MEM_ADDR_BITS + ALIGN_BITS - 1:ALIGN_BITS];

    always_ff @(posedge clk) begin
        if (resetn) begin
            busy           <= 1'b0;
            beat           <= '0;
            prev_valid     <= 1'b0;
            burst_is_write <= 1'b0;
        end else begin
            prev_valid <= cbus_req.valid;
            if (start) begin
                busy           <= 1'b1;
                beat           <= '0;
                burst_is_write <= cbus_req.is_write;
            end else if (busy) begin
                beat <= offset_t'(beat + 1'b1);
                if (beat == '1)
                    busy <= 1'b0;
            end
        end
    end

    // every word starts out as its own byte address
    always_ff @(posedge clk) begin
        if (resetn) begin
            for (int i = 0; i < MEM_WORDS; i++)
                mem[i] <= word_t'(i * DATA_BYTES);
        end else if (busy && burst_is_write) begin
            mem[word_idx] <= cbus_req.wdata;
        end
    end

    assign cbus_resp.okay  = busy;
    assign cbus_resp.last  = busy && beat == '1;
    assign cbus_resp.rdata = mem[word_idx];

    // the cache holds valid and direction for the whole burst
    last_ends_four_beats: assert property (@(posedge clk) disable iff (resetn)
        cbus_resp.okay |-> cbus_req.valid && cbus_req.is_write == burst_is_write)
        else $error("cache bus request changed during a burst");

endmodule

//--- dcache_top.sv
`timescale 1ns/1ps

module dcache_top (
    input  logic                   clk,
    input  logic                   resetn,
    input  dcache_pkg::dbus_req_t  dbus_req,
    output dcache_pkg::dbus_resp_t dbus_resp
);
    import dcache_pkg::*;

    // cache bus between the cache and main memory
    cbus_req_t  cbus_req;
    cbus_resp_t cbus_resp;

    dcache u_dcache (
        .clk       (clk),
        .resetn    (resetn),
        .dbus_req  (dbus_req),
        .dbus_resp (dbus_resp),
        .cbus_req  (cbus_req),
        .cbus_resp (cbus_resp)
    );

    cbus_memory u_cbus_memory (
        .clk       (clk),
        .resetn    (resetn),
        .cbus_req  (cbus_req),
        .cbus_resp (cbus_resp)
    );

endmodule

//--- tb_dcache.sv
`timescale 1ns/1ps

module tb_dcache;
    import dcache_pkg::*;

    localparam int ACCEPT_TIMEOUT   = 200;
    localparam int RESPONSE_TIMEOUT = 5;

    logic       clk;
    logic       resetn;
    dbus_req_t  dbus_req;
    dbus_resp_t dbus_resp;

    int   error_count;
    int   check_count;
    int   timeout_count;
    int   access_count;
    logic monitor_on;
    logic accept_seen;

    dcache_top u_dcache_top (
        .clk       (clk),
        .resetn    (resetn),
        .dbus_req  (dbus_req),
        .dbus_resp (dbus_resp)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // exactly one data_ok per accepted request in the next cycle
    always @(negedge clk) begin
        if (monitor_on) begin
            assert (dbus_resp.data_ok == accept_seen)
            else begin
                error_count++;
                $display("FAILED dbus_resp.data_ok: got %h expected %h",
                         dbus_resp.data_ok, accept_seen);
            end
            accept_seen = dbus_req.valid && dbus_resp.addr_ok;
        end
    end

    // drives one request on the data bus just after a rising edge
    task automatic run_access(input logic is_write, input word_t addr,
                              input wrten_t write_en, input word_t wdata,
                              input word_t expected, output logic completed);
        int wait_cycles;
        completed         = 1'b0;
        dbus_req.valid    = 1'b1;
        dbus_req.is_write = is_write;
        dbus_req.addr     = paddr_t'(addr);
        dbus_req.write_en = is_write ? write_en : '0;
        dbus_req.data     = wdata;

        // misses hold addr_ok low until the requested word is refilled
        wait_cycles = 0;
        @(negedge clk);
        while (!dbus_resp.addr_ok && wait_cycles < ACCEPT_TIMEOUT) begin
            wait_cycles++;
            @(negedge clk);
        end
        if (!dbus_resp.addr_ok) begin
            timeout_count++;
            $display("timeout: request to address %h not accepted within %0d cycles",
                     addr, ACCEPT_TIMEOUT);
            return;
        end

        @(posedge clk);
        #2;
        dbus_req.valid = 1'b0;

        wait_cycles = 0;
        @(negedge clk);
        while (!dbus_resp.data_ok && wait_cycles < RESPONSE_TIMEOUT) begin
            wait_cycles++;
            @(negedge clk);
        end
        if (!dbus_resp.data_ok) begin
            timeout_count++;
            $display("timeout: no data_ok for address %h within %0d cycles",
                     addr, RESPONSE_TIMEOUT);
            return;
        end

        if (!is_write) begin
            check_count++;
            assert (dbus_resp.data == expected)
            else begin
                error_count++;
                $display("FAILED dbus_resp.data at %h: got %h expected %h",
                         addr, dbus_resp.data, expected);
            end
        end
        completed = 1'b1;
    endtask

    // file columns are op (0 read, 1 write), address, byte enables, write data, expected data
    initial begin
        int     fd;
        int     fields;
        logic   running;
        logic   completed;
        logic [3:0] op;
        word_t  addr;
        wrten_t write_en;
        word_t  wdata;
        word_t  expected;

        error_count   = 0;
        check_count   = 0;
        timeout_count = 0;
        access_count  = 0;
        monitor_on    = 1'b0;
        accept_seen   = 1'b0;
        resetn        = 1'b1;
        dbus_req      = '0;

        fd = $fopen("dcache_stimulus.txt", "r");
        if (fd == 0) begin
            error_count++;
            $display("could not open dcache_stimulus.txt");
        end else begin
            repeat (2) @(posedge clk);
            #2;
            resetn     = 1'b0;
            monitor_on = 1'b1;
            running    = 1'b1;
            while (running && !$feof(fd)) begin
                fields = $fscanf(fd, "%h %h %h %h %h\n", op, addr, write_en, wdata, expected);
                if (fields == 5) begin
                    access_count++;
                    run_access(op[0], addr, write_en, wdata, expected, completed);
                    running = completed;
                    @(posedge clk);
                    #2;
                end else if (!$feof(fd)) begin
                    error_count++;
                    $display("malformed line %0d in the stimulus file", access_count + 1);
                    running = 1'b0;
                end
            end
            $fclose(fd);
            if (access_count == 0) begin
                error_count++;
                $display("the stimulus file holds no accesses");
            end
        end

        $display("accesses %0d, data checks %0d, errors %0d, timeouts %0d",
                 access_count, check_count, error_count, timeout_count);
        if (error_count == 0 && timeout_count == 0)
            $display("TEST PASSED");
        else
            $display("TEST FAILED");
        $finish;
    end

endmodule

//--- dcache_stimulus.txt
0 00000008 0 00000000 00000008
0 0000003c 0 00000000 0000003c
1 00000008 3 aabbccdd 00000000
0 00000008 0 00000000 0000ccdd
0 0000000c 0 00000000 0000000c
0 00000044 0 00000000 00000044
0 00000088 0 00000000 00000088
0 000000cc 0 00000000 000000cc
0 00000100 0 00000000 00000100
0 0000014c 0 00000000 0000014c
0 00000008 0 00000000 0000ccdd
1 00000010 f 11111111 00000000
1 00000054 f 22222222 00000000
1 00000098 f 33333333 00000000
1 000000dc f 44444444 00000000
0 00000010 0 00000000 11111111
0 00000110 0 00000000 00000110
0 00000010 0 00000000 11111111
0 00000054 0 00000000 22222222
0 00000098 0 00000000 33333333
0 000000dc 0 00000000 44444444

//--- verilog.f
+incdir+.
dcache_pkg.sv
plru.sv
dual_port_bram.sv
dcache.sv
cbus_memory.sv
dcache_top.sv
tb_dcache.sv

//--- run.sh
#!/bin/bash
# build and run the dcache testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f verilog.f --top-module tb_dcache
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

output=$(./obj_dir/Vtb_dcache)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if echo "$output" | grep -q "TEST PASSED"; then
    exit 0
fi
exit 1
